// ==== gteRegFile.f ====
source/gteRegPkg.sv
source/gteScreenFifo.sv
source/gteColorFifo.sv
source/gteIrFlags.sv
source/gteLeadCount.sv
source/gteReadMux.sv
source/gteRegFile.sv
verification/gteRegFileTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f gteRegFile.f \
	--top-module gteRegFileTb \
	-Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

// ==== source/gteColorFifo.sv ====
// Color FIFO and code register
`timescale 1ns/100ps

module gteColorFifo (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  gteRegPkg::regNum_t    i_regNum,
	input  logic                  i_write,
	input  gteRegPkg::word_t      i_dataIn,
	input  gteRegPkg::writeBack_t i_wb,
	output gteRegPkg::colorRegs_t o_color
);
	import gteRegPkg::*;

	logic [2:0] wrRgb;
	logic       wrRgbc;
	colorRegs_t color;

	assign wrRgb[0] = i_write && (i_regNum == REG_RGB0);
	assign wrRgb[1] = i_write && (i_regNum == REG_RGB1);
	assign wrRgb[2] = i_write && (i_regNum == REG_RGB2);
	assign wrRgbc   = i_write && (i_regNum == REG_RGBC);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			color <= '0;
		end else begin
			if (wrRgb[0])
				color.crgb0 <= i_dataIn;
			if (wrRgb[1])
				color.crgb1 <= i_dataIn;
			if (wrRgb[2])
				color.crgb2 <= i_dataIn;
			if (wrRgbc)
				color.crgb <= i_dataIn;

			// ------------------------------
			// Channel pushes, each overrides a CPU load on its own byte
			// ------------------------------
			if (i_wb.pushR) begin
				color.crgb0.r <= color.crgb1.r;
				color.crgb1.r <= color.crgb2.r;
				color.crgb2.r <= i_wb.colorValue;
			end
			if (i_wb.pushG) begin
				color.crgb0.g <= color.crgb1.g;
				color.crgb1.g <= color.crgb2.g;
				color.crgb2.g <= i_wb.colorValue;
			end
			// Blue push also carries the code byte along
			if (i_wb.pushB) begin
				color.crgb0.b    <= color.crgb1.b;
				color.crgb1.b    <= color.crgb2.b;
				color.crgb2.b    <= i_wb.colorValue;
				color.crgb0.code <= color.crgb1.code;
				color.crgb1.code <= color.crgb2.code;
				color.crgb2.code <= color.crgb.code;
			end
		end
	end

	assign o_color = color;

endmodule

// ==== source/gteIrFlags.sv ====
// IR registers and sticky flags
`timescale 1ns/100ps

module gteIrFlags (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  gteRegPkg::regNum_t    i_regNum,
	input  logic                  i_write,
	input  gteRegPkg::word_t      i_dataIn,
	input  gteRegPkg::writeBack_t i_wb,
	input  logic                  i_loadInstr,
	output gteRegPkg::irRegs_t    o_ir
);
	import gteRegPkg::*;

	logic [3:0] wrIrCpu;
	logic       wrIrgb;
	logic       wrFlag;
	half_t      irgbR;
	half_t      irgbG;
	half_t      irgbB;
	irRegs_t    ir;

	assign wrIrCpu[0] = i_write && (i_regNum == REG_IR0);
	assign wrIrCpu[1] = i_write && (i_regNum == REG_IR1);
	assign wrIrCpu[2] = i_write && (i_regNum == REG_IR2);
	assign wrIrCpu[3] = i_write && (i_regNum == REG_IR3);
	assign wrIrgb     = i_write && (i_regNum == REG_IRGB);
	assign wrFlag     = i_write && (i_regNum == REG_FLAG);

	// 5-bit color fields scaled up to IR range
	assign irgbR = {4'd0, i_dataIn[4:0], 7'd0};
	assign irgbG = {4'd0, i_dataIn[9:5], 7'd0};
	assign irgbB = {4'd0, i_dataIn[14:10], 7'd0};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			ir <= '0;
		end else begin
			// ------------------------------
			// IR0..IR3
			// ------------------------------
			if (wrIrCpu[0])
				ir.ir0 <= i_dataIn[15:0];
			if (wrIrCpu[1])
				ir.ir1 <= i_dataIn[15:0];
			if (wrIrCpu[2])
				ir.ir2 <= i_dataIn[15:0];
			if (wrIrCpu[3])
				ir.ir3 <= i_dataIn[15:0];
			if (wrIrgb) begin
				ir.ir1 <= irgbR;
				ir.ir2 <= irgbG;
				ir.ir3 <= irgbB;
			end
			// Datapath results come last so they take priority
			if (i_wb.wrIr[0])
				ir.ir0 <= i_wb.ir0Value;
			if (i_wb.wrIr[1])
				ir.ir1 <= i_wb.ir13Value;
			if (i_wb.wrIr[2])
				ir.ir2 <= i_wb.ir13Value;
			if (i_wb.wrIr[3])
				ir.ir3 <= i_wb.ir13Value;

			// ------------------------------
			// FLAGS
			// ------------------------------
			if (wrFlag) begin
				ir.flags <= i_dataIn[30:12];
			end else if (i_loadInstr) begin
				// New instruction starts from a clean set
				ir.flags <= i_wb.updateFlags;
			end else begin
				ir.flags <= ir.flags | i_wb.updateFlags;
			end
		end
	end

	assign o_ir = ir;

endmodule

// ==== source/gteLeadCount.sv ====
// Sign run counter
`timescale 1ns/100ps

module gteLeadCount (
	input  logic               i_clk,
	input  logic               i_rst,
	input  gteRegPkg::regNum_t i_regNum,
	input  logic               i_write,
	input  gteRegPkg::word_t   i_dataIn,
	output gteRegPkg::word_t   o_lzcs,
	output logic [5:0]         o_lzcr
);
	import gteRegPkg::*;

	word_t      lzcs;
	logic [5:0] count;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			lzcs <= '0;
		end else if (i_write && (i_regNum == REG_LZCS)) begin
			lzcs <= i_dataIn;
		end
	end

	// Highest bit that differs from the sign ends the run
	always_comb begin
		count = 6'd32;
		for (int i = 0; i < 31; i++) begin
			if (lzcs[i] != lzcs[31])
				count = 6'(31 - i);
		end
	end

	assign o_lzcs = lzcs;
	assign o_lzcr = count;

	// Sign bit always counts itself
	lzcrRange: assert property (@(posedge i_clk) disable iff (i_rst)
		(o_lzcr != 6'd0) && (o_lzcr <= 6'd32));

endmodule

// ==== source/gteReadMux.sv ====
// CPU read-back selection
`timescale 1ns/100ps

module gteReadMux (
	input  gteRegPkg::regNum_t     i_regNum,
	input  gteRegPkg::screenRegs_t i_screen,
	input  gteRegPkg::colorRegs_t  i_color,
	input  gteRegPkg::irRegs_t     i_ir,
	input  gteRegPkg::word_t       i_lzcs,
	input  logic [5:0]             i_lzcr,
	output gteRegPkg::word_t       o_dataOut
);
	import gteRegPkg::*;

	logic [4:0] r5;
	logic [4:0] g5;
	logic [4:0] b5;
	logic       flagSummary;

	// IR to 5-bit color with clamping
	function automatic logic [4:0] toColor5(input half_t value);
		if (value[15])
			return 5'd0;
		else if (value > 16'sh0F80)
			return 5'd31;
		return value[11:7];
	endfunction

	assign r5 = toColor5(i_ir.ir1);
	assign g5 = toColor5(i_ir.ir2);
	assign b5 = toColor5(i_ir.ir3);

	// Error summary bit 31
	assign flagSummary = (|i_ir.flags[18:11]) | (|i_ir.flags[6:1]);

	always_comb begin
		case (i_regNum)
			REG_RGBC: o_dataOut = i_color.crgb;
			REG_IR0:  o_dataOut = {{16{i_ir.ir0[15]}}, i_ir.ir0};
			REG_IR1:  o_dataOut = {{16{i_ir.ir1[15]}}, i_ir.ir1};
			REG_IR2:  o_dataOut = {{16{i_ir.ir2[15]}}, i_ir.ir2};
			REG_IR3:  o_dataOut = {{16{i_ir.ir3[15]}}, i_ir.ir3};
			REG_SXY0: o_dataOut = {i_screen.sy0, i_screen.sx0};
			REG_SXY1: o_dataOut = {i_screen.sy1, i_screen.sx1};
			REG_SXY2,
			REG_SXYP: o_dataOut = {i_screen.sy2, i_screen.sx2};
			REG_SZ0:  o_dataOut = {16'd0, i_screen.sz0};
			REG_SZ1:  o_dataOut = {16'd0, i_screen.sz1};
			REG_SZ2:  o_dataOut = {16'd0, i_screen.sz2};
			REG_SZ3:  o_dataOut = {16'd0, i_screen.sz3};
			REG_RGB0: o_dataOut = i_color.crgb0;
			REG_RGB1: o_dataOut = i_color.crgb1;
			REG_RGB2: o_dataOut = i_color.crgb2;
			REG_IRGB,
			REG_ORGB: o_dataOut = {17'd0, b5, g5, r5};
			REG_LZCS: o_dataOut = i_lzcs;
			REG_LZCR: o_dataOut = {26'd0, i_lzcr};
			REG_FLAG: o_dataOut = {flagSummary, i_ir.flags, 12'd0};
			default:  o_dataOut = '0;
		endcase
		// Flag bits live in the upper field only
		if (i_regNum == REG_FLAG)
			flagLowZero: assert (o_dataOut[11:0] == 12'd0);
	end

endmodule

// ==== source/gteRegFile.sv ====
// Coprocessor register file top
`timescale 1ns/100ps

module gteRegFile (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  gteRegPkg::regNum_t    i_regNum,
	input  logic                  i_write,
	input  gteRegPkg::word_t      i_dataIn,
	input  gteRegPkg::writeBack_t i_wb,
	input  logic                  i_loadInstr,
	output gteRegPkg::word_t      o_dataOut
);
	import gteRegPkg::*;

	screenRegs_t screen;
	colorRegs_t  color;
	irRegs_t     irRegs;
	word_t       lzcs;
	logic [5:0]  lzcr;

	// ------------------------------
	// Register blocks
	// ------------------------------
	gteScreenFifo i_gteScreenFifo (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_regNum (i_regNum),
		.i_write  (i_write),
		.i_dataIn (i_dataIn),
		.i_wb     (i_wb),
		.o_screen (screen)
	);

	gteColorFifo i_gteColorFifo (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_regNum (i_regNum),
		.i_write  (i_write),
		.i_dataIn (i_dataIn),
		.i_wb     (i_wb),
		.o_color  (color)
	);

	gteIrFlags i_gteIrFlags (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_regNum    (i_regNum),
		.i_write     (i_write),
		.i_dataIn    (i_dataIn),
		.i_wb        (i_wb),
		.i_loadInstr (i_loadInstr),
		.o_ir        (irRegs)
	);

	gteLeadCount i_gteLeadCount (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_regNum (i_regNum),
		.i_write  (i_write),
		.i_dataIn (i_dataIn),
		.o_lzcs   (lzcs),
		.o_lzcr   (lzcr)
	);

	// Combinational read-back
	gteReadMux i_gteReadMux (
		.i_regNum  (i_regNum),
		.i_screen  (screen),
		.i_color   (color),
		.i_ir      (irRegs),
		.i_lzcs    (lzcs),
		.i_lzcr    (lzcr),
		.o_dataOut (o_dataOut)
	);

endmodule

// ==== source/gteRegPkg.sv ====
// Register file definitions
package gteRegPkg;

	// ------------------------------
	// Widths
	// ------------------------------
	typedef logic [31:0]        word_t;
	typedef logic signed [15:0] half_t;
	// Bit 5 selects the control bank
	typedef logic [5:0]         regNum_t;
	// Stored as CPU bits 30..12
	typedef logic [18:0]        flags_t;

	// ------------------------------
	// Register numbers
	// ------------------------------
	localparam regNum_t REG_RGBC = 6'd6;
	localparam regNum_t REG_IR0  = 6'd8;
	localparam regNum_t REG_IR1  = 6'd9;
	localparam regNum_t REG_IR2  = 6'd10;
	localparam regNum_t REG_IR3  = 6'd11;
	localparam regNum_t REG_SXY0 = 6'd12;
	localparam regNum_t REG_SXY1 = 6'd13;
	localparam regNum_t REG_SXY2 = 6'd14;
	localparam regNum_t REG_SXYP = 6'd15;
	localparam regNum_t REG_SZ0  = 6'd16;
	localparam regNum_t REG_SZ1  = 6'd17;
	localparam regNum_t REG_SZ2  = 6'd18;
	localparam regNum_t REG_SZ3  = 6'd19;
	localparam regNum_t REG_RGB0 = 6'd20;
	localparam regNum_t REG_RGB1 = 6'd21;
	localparam regNum_t REG_RGB2 = 6'd22;
	localparam regNum_t REG_IRGB = 6'd28;
	localparam regNum_t REG_ORGB = 6'd29;
	localparam regNum_t REG_LZCS = 6'd30;
	localparam regNum_t REG_LZCR = 6'd31;
	localparam regNum_t REG_FLAG = 6'd63;

	// ------------------------------
	// Register groups
	// ------------------------------
	// Red in the low byte of a CPU word
	typedef struct packed {
		logic [7:0] code;
		logic [7:0] b;
		logic [7:0] g;
		logic [7:0] r;
	} rgbc_t;

	typedef struct packed {
		half_t sx0, sx1, sx2;
		half_t sy0, sy1, sy2;
		half_t sz0, sz1, sz2, sz3;
	} screenRegs_t;

	typedef struct packed {
		rgbc_t crgb0, crgb1, crgb2;
		rgbc_t crgb;
	} colorRegs_t;

	typedef struct packed {
		half_t  ir0, ir1, ir2, ir3;
		flags_t flags;
	} irRegs_t;

	// Datapath results and their push strobes
	typedef struct packed {
		logic       pushX, pushY, pushZ;
		logic       pushR, pushG, pushB;
		logic [3:0] wrIr;
		half_t      xyValue;
		half_t      szValue;
		logic [7:0] colorValue;
		half_t      ir0Value;
		half_t      ir13Value;
		flags_t     updateFlags;
	} writeBack_t;

endpackage

// ==== source/gteScreenFifo.sv ====
// Screen coordinate FIFOs
`timescale 1ns/100ps

module gteScreenFifo (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  gteRegPkg::regNum_t     i_regNum,
	input  logic                   i_write,
	input  gteRegPkg::word_t       i_dataIn,
	input  gteRegPkg::writeBack_t  i_wb,
	output gteRegPkg::screenRegs_t o_screen
);
	import gteRegPkg::*;

	logic [2:0]  wrSxy;
	logic        wrSxyP;
	logic [3:0]  wrSz;
	logic        shiftX;
	logic        shiftY;
	half_t       newX;
	half_t       newY;
	screenRegs_t screen;

	assign wrSxy[0] = i_write && (i_regNum == REG_SXY0);
	assign wrSxy[1] = i_write && (i_regNum == REG_SXY1);
	assign wrSxy[2] = i_write && (i_regNum == REG_SXY2);
	assign wrSxyP   = i_write && (i_regNum == REG_SXYP);
	assign wrSz[0]  = i_write && (i_regNum == REG_SZ0);
	assign wrSz[1]  = i_write && (i_regNum == REG_SZ1);
	assign wrSz[2]  = i_write && (i_regNum == REG_SZ2);
	assign wrSz[3]  = i_write && (i_regNum == REG_SZ3);

	// X and Y shift on their own strobes, SXYP shifts both
	assign shiftX = i_wb.pushX || wrSxyP;
	assign shiftY = i_wb.pushY || wrSxyP;
	assign newX   = i_wb.pushX ? i_wb.xyValue : half_t'(i_dataIn[15:0]);
	assign newY   = i_wb.pushY ? i_wb.xyValue : half_t'(i_dataIn[31:16]);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			screen <= '0;
		end else begin
			// Direct CPU loads, a shift in the same cycle overrides them
			if (wrSxy[0]) begin
				screen.sx0 <= i_dataIn[15:0];
				screen.sy0 <= i_dataIn[31:16];
			end
			if (wrSxy[1]) begin
				screen.sx1 <= i_dataIn[15:0];
				screen.sy1 <= i_dataIn[31:16];
			end
			if (wrSxy[2]) begin
				screen.sx2 <= i_dataIn[15:0];
				screen.sy2 <= i_dataIn[31:16];
			end
			if (wrSz[0])
				screen.sz0 <= i_dataIn[15:0];
			if (wrSz[1])
				screen.sz1 <= i_dataIn[15:0];
			if (wrSz[2])
				screen.sz2 <= i_dataIn[15:0];
			if (wrSz[3])
				screen.sz3 <= i_dataIn[15:0];

			if (shiftX) begin
				screen.sx0 <= screen.sx1;
				screen.sx1 <= screen.sx2;
				screen.sx2 <= newX;
			end
			if (shiftY) begin
				screen.sy0 <= screen.sy1;
				screen.sy1 <= screen.sy2;
				screen.sy2 <= newY;
			end
			// Z only moves on the datapath push
			if (i_wb.pushZ) begin
				screen.sz0 <= screen.sz1;
				screen.sz1 <= screen.sz2;
				screen.sz2 <= screen.sz3;
				screen.sz3 <= i_wb.szValue;
			end
		end
	end

	assign o_screen = screen;

	// One shared xyValue, so the datapath pushes X and Y in separate cycles
	pushXyExclusive: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_wb.pushX && i_wb.pushY));

endmodule

// ==== verification/gteRegFileTb.sv ====
// Register file testbench
`timescale 1ns/100ps

module gteRegFileTb;
	import gteRegPkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 10;

	// One table row is a drive cycle then a read cycle
	typedef struct packed {
		logic       write;
		regNum_t    wrReg;
		word_t      data;
		writeBack_t wb;
		logic       load;
		regNum_t    rdReg;
		word_t      expected;
	} step_t;

	logic       i_clk = 1'b0;
	logic       i_rst;
	regNum_t    i_regNum;
	logic       i_write;
	word_t      i_dataIn;
	writeBack_t i_wb;
	logic       i_loadInstr;
	word_t      o_dataOut;

	step_t steps[$];
	logic  tableReady = 1'b0;
	int    seed = 34750;
	int    checks = 0;
	int    errors = 0;

	gteRegFile i_gteRegFile (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_regNum    (i_regNum),
		.i_write     (i_write),
		.i_dataIn    (i_dataIn),
		.i_wb        (i_wb),
		.i_loadInstr (i_loadInstr),
		.o_dataOut   (o_dataOut)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	// ------------------------------
	// Expected value rules
	// ------------------------------
	function automatic word_t signExtend16(input logic [15:0] v);
		return word_t'($signed(v));
	endfunction

	// Summary bit is set by flags 18..11 and 6..1
	function automatic word_t flagWord(input flags_t f);
		logic summary;
		summary = ((f & 19'h7F87E) != 19'd0);
		return {summary, f, 12'd0};
	endfunction

	// Length of the run of bits that equal the sign bit
	function automatic word_t signRun(input word_t v);
		int n;
		n = 1;
		for (int i = 30; i >= 0; i--) begin
			if (v[i] != v[31])
				break;
			n++;
		end
		return word_t'(n);
	endfunction

	// ------------------------------
	// Table building
	// ------------------------------
	task automatic storeStep(input logic write, input regNum_t wrReg, input word_t data,
		input writeBack_t wb, input logic load, input regNum_t rdReg, input word_t expected);
		step_t s;
		s = '{write, wrReg, data, wb, load, rdReg, expected};
		steps.push_back(s);
	endtask

	task automatic cpuWrite(input regNum_t wrReg, input word_t data, input regNum_t rdReg,
		input word_t expected);
		storeStep(1'b1, wrReg, data, '0, 1'b0, rdReg, expected);
	endtask

	task automatic regRead(input regNum_t rdReg, input word_t expected);
		storeStep(1'b0, rdReg, 32'd0, '0, 1'b0, rdReg, expected);
	endtask

	task automatic datapathPush(input writeBack_t wb, input logic load, input regNum_t rdReg,
		input word_t expected);
		storeStep(1'b0, rdReg, 32'd0, wb, load, rdReg, expected);
	endtask

	task automatic buildTable();
		word_t      d;
		word_t      sxyp[3];
		logic [15:0] z[4];
		logic [7:0] kb;
		regNum_t    rn;
		writeBack_t wb;

		// After reset only LZCR reads nonzero
		for (int r = 0; r < 64; r++) begin
			rn = regNum_t'(r);
			regRead(rn, (rn == REG_LZCR) ? 32'd32 : 32'd0);
		end

		// Direct CPU loads and their read formats
		for (int k = 0; k < 4; k++) begin
			d = word_t'($random(seed));
			rn = REG_IR0 + regNum_t'(k);
			cpuWrite(rn, d, rn, signExtend16(d[15:0]));
			d = word_t'($random(seed));
			rn = REG_SZ0 + regNum_t'(k);
			cpuWrite(rn, d, rn, {16'd0, d[15:0]});
		end
		for (int k = 0; k < 3; k++) begin
			d = word_t'($random(seed));
			rn = REG_SXY0 + regNum_t'(k);
			cpuWrite(rn, d, rn, d);
			d = word_t'($random(seed));
			rn = REG_RGB0 + regNum_t'(k);
			cpuWrite(rn, d, rn, d);
		end
		d = word_t'($random(seed));
		cpuWrite(REG_RGBC, d, REG_RGBC, d);
		cpuWrite(6'd5, d, 6'd5, 32'd0);
		cpuWrite(6'd40, d, 6'd40, 32'd0);

		// SXYP pushes then separate X and Y pushes
		for (int k = 0; k < 3; k++) begin
			sxyp[k] = word_t'($random(seed));
			cpuWrite(REG_SXYP, sxyp[k], REG_SXYP, sxyp[k]);
		end
		regRead(REG_SXY0, sxyp[0]);
		regRead(REG_SXY1, sxyp[1]);
		regRead(REG_SXY2, sxyp[2]);
		wb = '0;
		wb.pushX = 1'b1;
		wb.xyValue = 16'h1234;
		datapathPush(wb, 1'b0, REG_SXY2, {sxyp[2][31:16], 16'h1234});
		wb = '0;
		wb.pushY = 1'b1;
		wb.xyValue = 16'hABCD;
		datapathPush(wb, 1'b0, REG_SXY2, 32'hABCD1234);
		regRead(REG_SXY1, sxyp[2]);
		regRead(REG_SXY0, sxyp[1]);

		// Z FIFO fills from SZ3
		for (int k = 0; k < 4; k++) begin
			d = word_t'($random(seed));
			z[k] = d[15:0];
			wb = '0;
			wb.pushZ = 1'b1;
			wb.szValue = d[15:0];
			datapathPush(wb, 1'b0, REG_SZ3, {16'd0, d[15:0]});
		end
		for (int k = 0; k < 4; k++)
			regRead(REG_SZ0 + regNum_t'(k), {16'd0, z[k]});

		// Three rounds of R, G, B pushes with code C5
		cpuWrite(REG_RGBC, 32'hC5302010, REG_RGBC, 32'hC5302010);
		for (int k = 1; k <= 3; k++) begin
			kb = 8'(k);
			wb = '0;
			wb.pushR = 1'b1;
			wb.colorValue = 8'h10 + kb;
			datapathPush(wb, 1'b0, REG_RGBC, 32'hC5302010);
			wb = '0;
			wb.pushG = 1'b1;
			wb.colorValue = 8'h20 + kb;
			datapathPush(wb, 1'b0, REG_RGBC, 32'hC5302010);
			wb = '0;
			wb.pushB = 1'b1;
			wb.colorValue = 8'h30 + kb;
			datapathPush(wb, 1'b0, REG_RGB2, {8'hC5, 8'h30 + kb, 8'h20 + kb, 8'h10 + kb});
		end
		regRead(REG_RGB0, 32'hC5312111);
		regRead(REG_RGB1, 32'hC5322212);

		// IRGB fields land in IR1..IR3 and read back unchanged
		d = word_t'($random(seed));
		cpuWrite(REG_IRGB, d, REG_IR1, {20'd0, d[4:0], 7'd0});
		regRead(REG_IR2, {20'd0, d[9:5], 7'd0});
		regRead(REG_IR3, {20'd0, d[14:10], 7'd0});
		regRead(REG_ORGB, {17'd0, d[14:0]});
		regRead(REG_IRGB, {17'd0, d[14:0]});
		// Clamp low and high then a plain field of 5
		cpuWrite(REG_IR1, 32'h0000FFF0, REG_IR1, 32'hFFFFFFF0);
		cpuWrite(REG_IR2, 32'h00001000, REG_IR2, 32'h00001000);
		cpuWrite(REG_IR3, 32'h00000280, REG_ORGB, 32'h000017E0);

		// Datapath IR write beats a CPU write in the same cycle
		wb = '0;
		wb.wrIr = 4'b0011;
		wb.ir0Value = 16'h8001;
		wb.ir13Value = 16'h0123;
		storeStep(1'b1, REG_IR1, 32'h00007777, wb, 1'b0, REG_IR1, 32'h00000123);
		regRead(REG_IR0, 32'hFFFF8001);

		// ------------------------------
		// Sticky flags
		// ------------------------------
		wb = '0;
		wb.updateFlags = 19'h00001;
		datapathPush(wb, 1'b0, REG_FLAG, flagWord(19'h00001));
		wb.updateFlags = 19'h00002;
		datapathPush(wb, 1'b0, REG_FLAG, flagWord(19'h00003));
		wb.updateFlags = 19'h00080;
		datapathPush(wb, 1'b1, REG_FLAG, flagWord(19'h00080));
		wb.updateFlags = 19'h00800;
		datapathPush(wb, 1'b0, REG_FLAG, flagWord(19'h00880));
		cpuWrite(REG_FLAG, 32'h80081FFF, REG_FLAG, flagWord(19'h00081));
		d = word_t'($random(seed));
		cpuWrite(REG_FLAG, d, REG_FLAG, flagWord(d[30:12]));

		// Sign run counts on arithmetically shifted random words
		cpuWrite(REG_LZCS, 32'h00000000, REG_LZCR, 32'd32);
		cpuWrite(REG_LZCS, 32'hFFFFFFFF, REG_LZCR, 32'd32);
		cpuWrite(REG_LZCS, 32'h40000000, REG_LZCR, 32'd1);
		for (int k = 0; k < 8; k++) begin
			d = word_t'($random(seed));
			d = word_t'($signed(d) >>> (4 * k));
			cpuWrite(REG_LZCS, d, REG_LZCR, signRun(d));
		end
		regRead(REG_LZCS, d);
	endtask

	// ------------------------------
	// Checking and stepping
	// ------------------------------
	task automatic compareValue(input string name, input word_t actual, input word_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error at %0d ns: %s is %08h, expected %08h",
				$time, name, actual, expected);
		end
	endtask

	task automatic applyStep(input step_t s, input int n);
		@(posedge i_clk);
		#1;
		i_write     = s.write;
		i_regNum    = s.wrReg;
		i_dataIn    = s.data;
		i_wb        = s.wb;
		i_loadInstr = s.load;
		@(posedge i_clk);
		#1;
		i_write     = 1'b0;
		i_regNum    = s.rdReg;
		i_dataIn    = '0;
		i_wb        = '0;
		i_loadInstr = 1'b0;
		// Read path has settled by mid cycle
		#(CLK_PERIOD / 2);
		compareValue($sformatf("o_dataOut (step %0d, reg %0d)", n, s.rdReg),
			o_dataOut, s.expected);
	endtask

	initial begin
		i_rst       = 1'b1;
		i_write     = 1'b0;
		i_regNum    = '0;
		i_dataIn    = '0;
		i_wb        = '0;
		i_loadInstr = 1'b0;
		buildTable();
		tableReady = 1'b1;
		repeat (RESET_CYCLES) @(posedge i_clk);
		#1;
		i_rst = 1'b0;
		foreach (steps[n])
			applyStep(steps[n], n);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Two cycles per row plus reset and some margin
	initial begin
		wait (tableReady);
		#((2 * steps.size() + RESET_CYCLES + 20) * CLK_PERIOD);
		$display("timeout: the table did not finish within its time limit");
		$display("tests failed");
		$finish;
	end

endmodule
